//--- hw/busDefsPkg.sv
// CPU bus definitions for the SCSI DMA front end
// Wishbone widths, register map and bit layout of control and status
package busDefsPkg;

    localparam int AdrWidth = 2;                     // Word address, four registers
    localparam int DatWidth = 32;                    // Longword data bus

    localparam logic [AdrWidth-1:0] RegScsi   = 2'd0; // Byte window onto the SCSI chip
    localparam logic [AdrWidth-1:0] RegCtrl   = 2'd1; // DMA enable and direction
    localparam logic [AdrWidth-1:0] RegStatus = 2'd2; // FIFO flags and fill count
    localparam logic [AdrWidth-1:0] RegFifo   = 2'd3; // Longword push and pop

    localparam int CtrlEnBit  = 0;                   // DMA enable
    localparam int CtrlDirBit = 1;                   // 0 chip to FIFO, 1 FIFO to chip

    localparam int StatEmptyBit   = 0;
    localparam int StatFullBit    = 1;
    localparam int StatCountLsb   = 8;               // Word count sits in 15:8
    localparam int StatCountWidth = 8;

endpackage

//--- hw/xferDefsPkg.sv
// Transfer side definitions for the SCSI DMA front end
// Sequencer states, DMA direction and the FIFO word with its byte view
package xferDefsPkg;

    // Direction as seen from the control register bit
    typedef enum logic {
        scsiToFifo = 1'b0,                           // Chip supplies, FIFO packs
        fifoToScsi = 1'b1                            // FIFO unpacks, chip consumes
    } dmaDir_t;

    typedef enum logic [2:0] {
        idle      = 3'd0,                            // Waiting for CPU or DMA work
        cpuStrobe = 3'd1,                            // CS with RE or WE held
        cpuDone   = 3'd2,                            // One cycle handshake back to slave
        dmaStrobe = 3'd3,                            // DACK with RE or WE held
        dmaDone   = 3'd4                             // FIFO push or pop pulse
    } seqState_t;

    // CPU side sees one longword, DMA side walks four bytes
    // Byte 0 lands in bits 31:24 so packing is MSB first
    typedef union packed {
        logic [31:0]         word;
        logic [0:3][7:0]     bytes;
    } fifoWord_t;

endpackage

//--- hw/scsiIfs.sv
// Internal links of the SCSI DMA front end
// seqCtrlIf carries CPU byte cycles and DMA control, fifoPortIf the byte side
`timescale 1ns/1ns

interface seqCtrlIf import xferDefsPkg::*; ();
    logic       cpuReq;                              // Held until cpuDone
    logic       cpuWrite;                            // High for a byte write
    logic [7:0] cpuWrByte;                           // Byte for the chip
    logic       dmaEn;
    dmaDir_t    dmaDir;
    logic [7:0] cpuRdByte;                           // Byte returned by the chip
    logic       cpuDone;                             // One cycle, CPU cycle finished

    modport slave (
        output cpuReq, cpuWrite, cpuWrByte, dmaEn, dmaDir,
        input  cpuRdByte, cpuDone
    );

    modport seq (
        input  cpuReq, cpuWrite, cpuWrByte, dmaEn, dmaDir,
        output cpuRdByte, cpuDone
    );
endinterface

interface fifoPortIf ();
    logic       pushByte;                            // One cycle pulse
    logic       popByte;                             // One cycle pulse
    logic [7:0] byteIn;
    logic [7:0] byteOut;                             // Current byte at the head
    logic       full;
    logic       empty;

    modport seq (
        output pushByte, popByte, byteIn,
        input  byteOut, full, empty
    );

    modport fifo (
        input  pushByte, popByte, byteIn,
        output byteOut, full, empty
    );
endinterface

//--- hw/wbRegSlave.sv
// Wishbone classic slave of the SCSI DMA front end
// Register decode, control and status, longword FIFO access and byte window requests
`timescale 1ns/1ns

module wbRegSlave import busDefsPkg::*, xferDefsPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  logic                          CLK135,
    input  logic                          AS_,
    input  logic                          wbCyc_i,
    input  logic                          wbStb_i,
    input  logic                          wbWe_i,
    input  logic [AdrWidth-1:0]           wbAdr_i,
    input  logic [DatWidth-1:0]           wbDat_i,
    output logic [DatWidth-1:0]           wbDat_o,
    output logic                          wbAck_o,
    seqCtrlIf.slave                       sc,
    input  logic [DatWidth-1:0]           wordOut_i,
    input  logic                          fifoFull_i,
    input  logic                          fifoEmpty_i,
    input  logic [$clog2(FifoDepth+1)-1:0] fifoCount_i,
    output logic                          pushWord_o,
    output logic                          popWord_o,
    output logic [DatWidth-1:0]           wordIn_o
);

    logic                access;                     // New cycle, not the ack cycle
    logic                regAccess;                  // Control, status or FIFO
    logic                scsiStart;                  // Byte window cycle begins
    logic [DatWidth-1:0] statusWord;
    logic [DatWidth-1:0] rdMux;

    assign access    = wbCyc_i && wbStb_i && !wbAck_o;
    assign regAccess = access && (wbAdr_i != RegScsi);
    assign scsiStart = access && (wbAdr_i == RegScsi) && !sc.cpuReq;

    // Guarded longword side, dropped accesses still ack
    assign pushWord_o = regAccess && wbWe_i && (wbAdr_i == RegFifo) && !fifoFull_i;
    assign popWord_o  = regAccess && !wbWe_i && (wbAdr_i == RegFifo) && !fifoEmpty_i;
    assign wordIn_o   = wbDat_i;

    always_comb begin
        statusWord = '0;
        statusWord[StatEmptyBit] = fifoEmpty_i;
        statusWord[StatFullBit]  = fifoFull_i;
        statusWord[StatCountLsb +: StatCountWidth] = StatCountWidth'(fifoCount_i);
        case (wbAdr_i)
            RegCtrl: begin
                rdMux = '0;
                rdMux[CtrlEnBit]  = sc.dmaEn;
                rdMux[CtrlDirBit] = sc.dmaDir;
            end
            RegStatus: rdMux = statusWord;
            RegFifo:   rdMux = fifoEmpty_i ? '0 : wordOut_i; // Empty pop reads zero
            default:   rdMux = '0;
        endcase
    end

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            wbAck_o     <= 1'b0;
            sc.cpuReq   <= 1'b0;
            sc.cpuWrite <= 1'b0;
            sc.dmaEn    <= 1'b0;
            sc.dmaDir   <= scsiToFifo;
        end else begin
            wbAck_o <= regAccess || sc.cpuDone;      // Single cycle either way
            if (scsiStart) begin
                sc.cpuReq   <= 1'b1;                 // Hold until sequencer finishes
                sc.cpuWrite <= wbWe_i;
            end else if (sc.cpuDone) begin
                sc.cpuReq   <= 1'b0;
            end
            if (regAccess && wbWe_i && (wbAdr_i == RegCtrl)) begin
                sc.dmaEn  <= wbDat_i[CtrlEnBit];
                sc.dmaDir <= dmaDir_t'(wbDat_i[CtrlDirBit]);
            end
        end
    end

    always_ff @(posedge CLK135) begin
        if (regAccess) wbDat_o <= rdMux;
        else if (sc.cpuDone) wbDat_o <= DatWidth'(sc.cpuRdByte); // Chip byte in 7:0
        if (scsiStart) sc.cpuWrByte <= wbDat_i[7:0];
    end

endmodule

//--- hw/scsiSequencer.sv
// SCSI chip sequencer
// Arbitrates CPU byte cycles against DMA bytes and drives the chip strobes
`timescale 1ns/1ns

module scsiSequencer import xferDefsPkg::*; #(
    parameter int StrobeCycles = 2
) (
    input  logic       CLK135,
    input  logic       AS_,
    seqCtrlIf.seq      sc,
    fifoPortIf.seq     fp,
    input  logic       scsiDreqN_i,
    input  logic [7:0] scsiDat_i,
    output logic       scsiCs_o,
    output logic       scsiRe_o,
    output logic       scsiWe_o,
    output logic       scsiDack_o,
    output logic [7:0] scsiDat_o
);

    localparam int CntW = (StrobeCycles > 1) ? $clog2(StrobeCycles) : 1;

    seqState_t       state;
    logic [CntW-1:0] strobeCnt;                      // Strobe cycles left minus one
    dmaDir_t         xferDir;                        // Direction of the byte in flight
    logic            dmaGo;                          // DMA may start a byte
    logic            lastStrobe;
    logic [7:0]      datLatch;                       // Byte read from the chip

    // Chip asks, DMA enabled, and FIFO has room or data
    assign dmaGo = sc.dmaEn && !scsiDreqN_i &&
                   ((sc.dmaDir == scsiToFifo) ? !fp.full : !fp.empty);

    assign lastStrobe = ((state == cpuStrobe) || (state == dmaStrobe)) && (strobeCnt == '0);

    assign sc.cpuDone   = (state == cpuDone);
    assign sc.cpuRdByte = datLatch;
    assign fp.byteIn    = datLatch;
    assign fp.pushByte  = (state == dmaDone) && (xferDir == scsiToFifo);
    assign fp.popByte   = (state == dmaDone) && (xferDir == fifoToScsi);

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            state      <= idle;
            strobeCnt  <= '0;
            xferDir    <= scsiToFifo;
            scsiCs_o   <= 1'b0;
            scsiRe_o   <= 1'b0;
            scsiWe_o   <= 1'b0;
            scsiDack_o <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (sc.cpuReq) begin             // CPU wins at idle
                        state     <= cpuStrobe;
                        strobeCnt <= CntW'(StrobeCycles - 1);
                        scsiCs_o  <= 1'b1;
                        scsiRe_o  <= !sc.cpuWrite;
                        scsiWe_o  <= sc.cpuWrite;
                    end else if (dmaGo) begin
                        state      <= dmaStrobe;
                        strobeCnt  <= CntW'(StrobeCycles - 1);
                        xferDir    <= sc.dmaDir;     // Latched for the push or pop
                        scsiDack_o <= 1'b1;
                        scsiRe_o   <= (sc.dmaDir == scsiToFifo);
                        scsiWe_o   <= (sc.dmaDir == fifoToScsi);
                    end
                end
                cpuStrobe, dmaStrobe: begin
                    if (lastStrobe) begin            // Drop every strobe together
                        scsiCs_o   <= 1'b0;
                        scsiRe_o   <= 1'b0;
                        scsiWe_o   <= 1'b0;
                        scsiDack_o <= 1'b0;
                        state      <= (state == cpuStrobe) ? cpuDone : dmaDone;
                    end else begin
                        strobeCnt <= strobeCnt - 1'b1;
                    end
                end
                cpuDone, dmaDone: state <= idle;     // Handshake cycle
                default: state <= idle;
            endcase
        end
    end

    // Outgoing byte is fixed while at idle, then held through the strobe
    always_ff @(posedge CLK135) begin
        if (state == idle) scsiDat_o <= sc.cpuReq ? sc.cpuWrByte : fp.byteOut;
        if (lastStrobe && scsiRe_o) datLatch <= scsiDat_i; // Sample on last strobe cycle
    end

endmodule

//--- hw/byteFifo.sv
// Longword FIFO with byte packing and unpacking
// Byte side packs and unpacks MSB first, word side moves whole longwords
`timescale 1ns/1ns

module byteFifo import xferDefsPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  logic                           CLK135,
    input  logic                           AS_,
    fifoPortIf.fifo                        fp,
    input  logic                           pushWord_i,
    input  logic                           popWord_i,
    input  fifoWord_t                      wordIn_i,
    output fifoWord_t                      wordOut_o,
    output logic                           fifoFull_o,
    output logic                           fifoEmpty_o,
    output logic [$clog2(FifoDepth+1)-1:0] fifoCount_o
);

    localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntW = $clog2(FifoDepth + 1);

    fifoWord_t       mem [FifoDepth];
    fifoWord_t       stage;                          // Partly packed word
    fifoWord_t       packWord;                       // Stage with the incoming byte
    logic [PtrW-1:0] nextIn, nextOut;
    logic [1:0]      packPtr, unpackPtr;
    logic [CntW-1:0] count;
    logic            doPush, doPop;

    function automatic logic [PtrW-1:0] bumpPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1; // Circular wrap
    endfunction

    always_comb begin
        packWord = stage;
        packWord.bytes[packPtr] = fp.byteIn;
    end

    assign doPush = pushWord_i || (fp.pushByte && (packPtr == 2'd3)); // Commit on byte 3
    assign doPop  = popWord_i || (fp.popByte && (unpackPtr == 2'd3));

    assign wordOut_o   = mem[nextOut];
    assign fp.byteOut  = mem[nextOut].bytes[unpackPtr];
    assign fifoFull_o  = (count == CntW'(FifoDepth));
    assign fifoEmpty_o = (count == '0);
    assign fifoCount_o = count;
    assign fp.full     = fifoFull_o;
    assign fp.empty    = fifoEmpty_o;

    always_ff @(posedge CLK135) begin
        if (fp.pushByte) stage <= packWord;
        if (doPush) mem[nextIn] <= pushWord_i ? wordIn_i : packWord;
    end

    always_ff @(posedge CLK135 or posedge AS_) begin
        if (AS_) begin
            nextIn    <= '0;
            nextOut   <= '0;
            packPtr   <= '0;
            unpackPtr <= '0;
            count     <= '0;
        end else begin
            if (fp.pushByte) packPtr <= packPtr + 2'd1; // Word side leaves these alone
            if (fp.popByte) unpackPtr <= unpackPtr + 2'd1;
            if (doPush) nextIn <= bumpPtr(nextIn);
            if (doPop) nextOut <= bumpPtr(nextOut);
            count <= count + CntW'(doPush) - CntW'(doPop);
        end
    end

endmodule

//--- hw/scsiDmaTop.sv
// SCSI DMA front end top level
// Wishbone register slave, chip sequencer and byte FIFO with plain outside ports
`timescale 1ns/1ns

module scsiDmaTop import busDefsPkg::*; #(
    parameter int FifoDepth    = 4,                  // Longwords
    parameter int StrobeCycles = 2                   // Clocks per chip strobe
) (
    input  logic                CLK135,
    input  logic                AS_,
    input  logic                wbCyc_i,
    input  logic                wbStb_i,
    input  logic                wbWe_i,
    input  logic [AdrWidth-1:0] wbAdr_i,
    input  logic [DatWidth-1:0] wbDat_i,
    output logic [DatWidth-1:0] wbDat_o,
    output logic                wbAck_o,
    input  logic                scsiDreqN_i,
    input  logic [7:0]          scsiDat_i,
    output logic                scsiCs_o,
    output logic                scsiRe_o,
    output logic                scsiWe_o,
    output logic                scsiDack_o,
    output logic [7:0]          scsiDat_o
);

    logic                           pushWord, popWord;
    logic [DatWidth-1:0]            wordIn, wordOut;
    logic                           fifoFull, fifoEmpty;
    logic [$clog2(FifoDepth+1)-1:0] fifoCount;

    seqCtrlIf  seqCtrl ();                           // Slave to sequencer
    fifoPortIf fifoPort ();                          // Sequencer to FIFO byte side

    wbRegSlave #(.FifoDepth(FifoDepth)) regSlave (
        .CLK135, .AS_, .wbCyc_i, .wbStb_i, .wbWe_i, .wbAdr_i, .wbDat_i, .wbDat_o, .wbAck_o,
        .sc(seqCtrl), .wordOut_i(wordOut), .fifoFull_i(fifoFull), .fifoEmpty_i(fifoEmpty),
        .fifoCount_i(fifoCount), .pushWord_o(pushWord), .popWord_o(popWord), .wordIn_o(wordIn)
    );

    scsiSequencer #(.StrobeCycles(StrobeCycles)) sequencer (
        .CLK135, .AS_, .sc(seqCtrl), .fp(fifoPort), .scsiDreqN_i, .scsiDat_i,
        .scsiCs_o, .scsiRe_o, .scsiWe_o, .scsiDack_o, .scsiDat_o
    );

    byteFifo #(.FifoDepth(FifoDepth)) fifo (
        .CLK135, .AS_, .fp(fifoPort), .pushWord_i(pushWord), .popWord_i(popWord),
        .wordIn_i(wordIn), .wordOut_o(wordOut), .fifoFull_o(fifoFull),
        .fifoEmpty_o(fifoEmpty), .fifoCount_o(fifoCount)
    );

endmodule

//--- tests/tbClockGen.sv
// Testbench clock and reset source
// 40 ns clock, reset held for the first 4 cycles
`timescale 1ns/1ns

module tbClockGen (
    output logic CLK135,
    output logic AS_
);
    initial begin
        CLK135 = 1'b0;
        forever #20 CLK135 = ~CLK135;                // 40 ns period
    end

    initial begin
        AS_ = 1'b1;
        repeat (4) @(posedge CLK135);
        @(negedge CLK135) AS_ = 1'b0;                // Release away from the active edge
    end
endmodule

//--- tests/scsiDmaChecker.sv
// Response checker of the SCSI DMA testbench
// Compares bus reads and chip bytes against queued expectations, keeps counts
`timescale 1ns/1ns

module scsiDmaChecker (
    input logic        CLK135,
    input logic        AS_,
    input logic        wbCyc_i,
    input logic        wbAck_i,
    input logic [31:0] wbDat_i,
    input logic        scsiCs_i,
    input logic        scsiRe_i,
    input logic        scsiWe_i,
    input logic        scsiDack_i,
    input logic [7:0]  scsiDat_i
);
    int          errCount = 0;
    int          checkCount = 0;
    int          testErr = 0;
    int          testNo = 0;
    logic [31:0] expWord;
    bit          rdPending = 0;                      // A read result is awaited
    logic [7:0]  expBytes [$];                       // Bytes the chip should see
    logic [7:0]  expB;
    bit          weSeen = 0;
    bit          cycSeen = 0;

    task automatic expectRead(input logic [31:0] w);
        expWord = w;
        rdPending = 1;
    endtask

    task automatic expectByte(input logic [7:0] b);
        expBytes.push_back(b);
    endtask

    task automatic noteError(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errCount++;
        testErr++;
    endtask

    always @(posedge CLK135) begin
        if (!AS_) begin
            if (wbCyc_i) cycSeen = 1;
            if (!cycSeen && (scsiCs_i || scsiRe_i || scsiWe_i || scsiDack_i))
                noteError("chip strobe seen before the first bus access");
            if (wbAck_i && rdPending) begin      // Ack cycle, data is stable
                rdPending = 0;
                checkCount++;
                if (wbDat_i !== expWord) begin
                    $display("FAILED at %0t: read 0x%08h, expected 0x%08h",
                             $time, wbDat_i, expWord);
                    errCount++;
                    testErr++;
                end
            end
            if (scsiWe_i && !weSeen) begin       // First cycle of a write strobe
                checkCount++;
                if (expBytes.size() == 0) begin
                    noteError("chip received a byte that was not expected");
                end else begin
                    expB = expBytes.pop_front();
                    if (scsiDat_i !== expB) begin
                        $display("FAILED at %0t: chip byte 0x%02h, expected 0x%02h",
                                 $time, scsiDat_i, expB);
                        errCount++;
                        testErr++;
                    end
                end
            end
            weSeen = scsiWe_i;
        end
    end

    task automatic endTest(input string name);
        if (expBytes.size() != 0)
            noteError($sformatf("%0d expected chip bytes never arrived", expBytes.size()));
        if (rdPending) noteError("a read never completed");
        expBytes.delete();
        rdPending = 0;
        testNo++;
        $display("Test %0d %s: %s", testNo, name, (testErr == 0) ? "ok" : "errors");
        testErr = 0;
    endtask

    task automatic report();
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
    endtask
endmodule

//--- tests/scsiDmaTb.sv
// Testbench of the SCSI DMA front end
// Table driven Wishbone stimulus, a SCSI chip model and a watchdog
`timescale 1ns/1ns

module scsiDmaTb import busDefsPkg::*; ();
    localparam int OpWr = 0, OpRd = 1, OpSupply = 2, OpWant = 3;
    localparam int OpWait = 4, OpExpW = 5, OpMark = 6;

    typedef struct {
        int          op;
        logic [1:0]  adr;
        logic [31:0] dat;                            // Write data, count or test index
        logic [31:0] exp;                            // Expected read value
    } step_t;

    logic CLK135, AS_;
    logic wbCyc_i, wbStb_i, wbWe_i, wbAck_o;
    logic [AdrWidth-1:0] wbAdr_i;
    logic [DatWidth-1:0] wbDat_i, wbDat_o;
    logic scsiDreqN_i, scsiCs_o, scsiRe_o, scsiWe_o, scsiDack_o;
    logic [7:0] scsiDat_i, scsiDat_o;

    step_t       tbl [$];
    string       names [5];
    logic [7:0]  dmaBytes [8];
    logic [7:0]  dmaQ [$];                           // Bytes the chip still has to supply
    logic [31:0] w0, w1;
    logic [7:0]  chipReg;
    int          dmaWant = 0;                        // DMA bytes the chip still requests
    int          seed = 32'h9998;
    bit          inDma = 0;
    bit          dmaRead = 0;

    tbClockGen clkGen (.CLK135, .AS_);

    scsiDmaTop dut (
        .CLK135, .AS_, .wbCyc_i, .wbStb_i, .wbWe_i, .wbAdr_i, .wbDat_i, .wbDat_o,
        .wbAck_o, .scsiDreqN_i, .scsiDat_i, .scsiCs_o, .scsiRe_o, .scsiWe_o,
        .scsiDack_o, .scsiDat_o
    );

    scsiDmaChecker chk (
        .CLK135, .AS_, .wbCyc_i, .wbAck_i(wbAck_o), .wbDat_i(wbDat_o),
        .scsiCs_i(scsiCs_o), .scsiRe_i(scsiRe_o), .scsiWe_i(scsiWe_o),
        .scsiDack_i(scsiDack_o), .scsiDat_i(scsiDat_o)
    );

    // Chip model, one byte register plus DMA request handling
    always @(negedge CLK135) begin
        if (scsiCs_o && scsiWe_o) chipReg <= scsiDat_o;
        if (scsiCs_o && scsiRe_o) scsiDat_i <= chipReg;
        if (scsiDack_o) begin
            if (scsiRe_o && dmaQ.size() > 0) scsiDat_i <= dmaQ[0];
            dmaRead = scsiRe_o;
            inDma = 1;
        end else if (inDma) begin                    // DMA byte just ended
            inDma = 0;
            if (dmaRead) void'(dmaQ.pop_front());
            dmaWant--;
        end
        scsiDreqN_i <= (dmaWant <= 0);               // Active low request
    end

    task automatic addStep(input int op, input logic [1:0] adr,
                           input logic [31:0] dat, input logic [31:0] exp);
        step_t s;
        s = '{op, adr, dat, exp};
        tbl.push_back(s);
    endtask

    task automatic busCycle(input logic we, input logic [1:0] adr, input logic [31:0] dat);
        int n;
        n = 0;
        wbCyc_i = 1'b1;
        wbStb_i = 1'b1;
        wbWe_i  = we;
        wbAdr_i = adr;
        wbDat_i = dat;
        do begin
            @(negedge CLK135);
            n++;
        end while (!wbAck_o && n < 200);
        if (!wbAck_o) chk.noteError("bus cycle got no ack");
        wbCyc_i = 1'b0;
        wbStb_i = 1'b0;
        wbWe_i  = 1'b0;
        @(negedge CLK135);                           // Ack cycle ends, checker has sampled it
    endtask

    task automatic buildTable();
        int i;
        for (i = 0; i < 8; i++) dmaBytes[i] = 8'($random(seed));
        w0 = {dmaBytes[0], dmaBytes[1], dmaBytes[2], dmaBytes[3]}; // First byte on top
        w1 = {dmaBytes[4], dmaBytes[5], dmaBytes[6], dmaBytes[7]};
        names = '{"reset status", "byte window", "chip to FIFO", "FIFO to chip",
                  "FIFO limits"};
        addStep(OpRd, RegStatus, 0, 32'h0000_0001);
        addStep(OpMark, 0, 0, 0);
        addStep(OpWr, RegScsi, 32'h0000_00A5, 0);
        addStep(OpRd, RegScsi, 0, 32'h0000_00A5);
        addStep(OpMark, 0, 1, 0);
        addStep(OpSupply, 0, 8, 0);
        addStep(OpWr, RegCtrl, 32'h1, 0);
        addStep(OpWait, 0, 0, 0);
        addStep(OpWr, RegCtrl, 32'h0, 0);
        addStep(OpRd, RegStatus, 0, 32'h0000_0200);
        addStep(OpRd, RegFifo, 0, w0);
        addStep(OpRd, RegFifo, 0, w1);
        addStep(OpMark, 0, 2, 0);
        addStep(OpWr, RegFifo, 32'h1122_3344, 0);
        addStep(OpWr, RegFifo, 32'h5566_7788, 0);
        addStep(OpExpW, 0, 32'h1122_3344, 0);
        addStep(OpExpW, 0, 32'h5566_7788, 0);
        addStep(OpWant, 0, 8, 0);
        addStep(OpWr, RegCtrl, 32'h3, 0);            // Enable, FIFO to chip
        addStep(OpWait, 0, 0, 0);
        addStep(OpWr, RegCtrl, 32'h0, 0);
        addStep(OpRd, RegStatus, 0, 32'h0000_0001);
        addStep(OpMark, 0, 3, 0);
        for (i = 0; i < 4; i++) addStep(OpWr, RegFifo, 32'hC0DE_0000 + i, 0);
        addStep(OpRd, RegStatus, 0, 32'h0000_0402);  // Full with four words
        addStep(OpWr, RegFifo, 32'hC0DE_0004, 0);    // Dropped while full
        for (i = 0; i < 4; i++) addStep(OpRd, RegFifo, 0, 32'hC0DE_0000 + i);
        addStep(OpRd, RegFifo, 0, 32'h0);            // Empty pop reads zero
        addStep(OpRd, RegStatus, 0, 32'h0000_0001);
        addStep(OpMark, 0, 4, 0);
    endtask

    initial begin
        int i, n;
        wbCyc_i = 1'b0;
        wbStb_i = 1'b0;
        wbWe_i = 1'b0;
        wbAdr_i = '0;
        wbDat_i = '0;
        scsiDreqN_i = 1'b1;
        scsiDat_i = '0;
        buildTable();
        wait (!AS_);
        @(negedge CLK135);
        for (i = 0; i < tbl.size(); i++) begin
            case (tbl[i].op)
                OpWr: begin
                    if (tbl[i].adr == RegScsi) chk.expectByte(tbl[i].dat[7:0]);
                    busCycle(1'b1, tbl[i].adr, tbl[i].dat);
                end
                OpRd: begin
                    chk.expectRead(tbl[i].exp);
                    busCycle(1'b0, tbl[i].adr, 0);
                end
                OpSupply: begin
                    foreach (dmaBytes[k]) dmaQ.push_back(dmaBytes[k]);
                    dmaWant += tbl[i].dat;
                end
                OpWant: dmaWant += tbl[i].dat;
                OpWait: begin
                    n = 0;
                    while (dmaWant > 0 && n < 400) begin
                        @(negedge CLK135);
                        n++;
                    end
                    if (dmaWant > 0) chk.noteError("DMA transfer did not complete");
                    @(negedge CLK135);
                end
                OpExpW: for (n = 0; n < 4; n++) chk.expectByte(tbl[i].dat[31-8*n -: 8]);
                default: chk.endTest(names[tbl[i].dat]);
            endcase
        end
        chk.report();
        if (chk.errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog scaled by the table length plus reset
    initial begin
        #1;
        #(tbl.size() * 400 + 4 * 40);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end
endmodule

//--- scsiDma.f
hw/busDefsPkg.sv
hw/xferDefsPkg.sv
hw/scsiIfs.sv
hw/wbRegSlave.sv
hw/scsiSequencer.sv
hw/byteFifo.sv
hw/scsiDmaTop.sv
tests/tbClockGen.sv
tests/scsiDmaChecker.sv
tests/scsiDmaTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the SCSI DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f scsiDma.f --top-module scsiDmaTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
